/* verilog/thor_defs.svh */
`ifndef THOR_DEFS_SVH
`define THOR_DEFS_SVH

// ============================================================
// Architectural widths and counts
// ============================================================

// Data word
`define THOR_VALUE_W 64

// Whole instruction word
`define THOR_INSN_W 40

// Opcode field, bits 6:0 in every format
`define THOR_OPC_W 7

// Register index and register count
`define THOR_REG_W 6
`define THOR_REG_N 64

// Function field of the register format
`define THOR_FUNC_W 9

// Signed immediate of the immediate format
`define THOR_IMM_W 21

`endif

/* verilog/thor_pkg.sv */
`include "thor_defs.svh"

package thor_pkg;

	// One data word and one register index
	typedef logic [`THOR_VALUE_W-1:0] value_t;
	typedef logic [`THOR_REG_W-1:0] reg_idx_t;

	// ============================================================
	// Instruction encodings
	// ============================================================

	typedef enum logic [`THOR_OPC_W-1:0] {
		R2    = 7'h02,
		ADDI  = 7'h04,
		SUBFI = 7'h05,
		ANDI  = 7'h08,
		ORI   = 7'h09,
		XORI  = 7'h0A,
		CMPI  = 7'h0B,
		CMPUI = 7'h0C,
		ADD2R = 7'h14,
		AND2R = 7'h18,
		OR2R  = 7'h19,
		XOR2R = 7'h1A,
		SEQI  = 7'h26,
		SNEI  = 7'h27,
		SLTI  = 7'h28,
		SGTI  = 7'h29,
		SLTUI = 7'h2A,
		SGTUI = 7'h2B
	} opcode_e;

	// Function codes under R2
	typedef enum logic [`THOR_FUNC_W-1:0] {
		F_ADD = 9'h004,
		F_SUB = 9'h005,
		F_AND = 9'h008,
		F_OR  = 9'h009,
		F_XOR = 9'h00A
	} func_e;

	// Register format, opcode in the low bits
	typedef struct packed {
		func_e func;
		reg_idx_t rc;
		reg_idx_t rb;
		reg_idx_t ra;
		reg_idx_t rt;
		opcode_e opcode;
	} insn_r3_t;

	// Immediate format, same low 19 bits as the register format
	typedef struct packed {
		logic signed [`THOR_IMM_W-1:0] imm;
		reg_idx_t ra;
		reg_idx_t rt;
		opcode_e opcode;
	} insn_ri_t;

	// One instruction word, read either way
	typedef union packed {
		insn_r3_t r3;
		insn_ri_t ri;
	} insn_t;

	// ALU operations of the execute stage
	typedef enum logic [3:0] {
		A_ADD3, A_SUB3, A_AND3, A_OR3, A_XOR3,
		A_RSUB,
		A_CMP, A_CMPU,
		A_SEQ, A_SNE, A_SLT, A_SGT, A_SLTU, A_SGTU
	} alu_op_e;

endpackage

/* verilog/thor_if.sv */
// ============================================================
// Register file read port
// ============================================================
interface rf_read_if import thor_pkg::*; ();
	// Read indices, driven by decode
	reg_idx_t ra;
	reg_idx_t rb;
	reg_idx_t rc;
	// Read data, returned in the same cycle
	value_t a;
	value_t b;
	value_t c;

	modport reader(output ra, rb, rc, input a, b, c);
	modport owner(input ra, rb, rc, output a, b, c);
endinterface

// ============================================================
// Decode to execute bundle
// ============================================================
interface dec_exe_if import thor_pkg::*; ();
	logic valid;
	alu_op_e alu_op;
	reg_idx_t rt;
	// Operands already selected and forwarded
	value_t a;
	value_t b;
	value_t c;
	// Clear for an instruction with no effect
	logic rfwr;

	modport source(output valid, alu_op, rt, a, b, c, rfwr);
	modport sink(input valid, alu_op, rt, a, b, c, rfwr);
endinterface

/* verilog/thor_decode.sv */
`include "thor_defs.svh"

module thor_decode import thor_pkg::*; (
	input logic clk_g,
	input logic rst_i,
	input logic insn_valid_i,
	input insn_t insn_i,
	rf_read_if.reader rf,
	dec_exe_if.source de,
	input logic ex_valid_i,
	input reg_idx_t ex_rt_i,
	input value_t ex_res_i
);

	logic dval;
	insn_t ir;
	value_t imm_x;
	alu_op_e op;
	logic rfwr;
	logic use_imm;
	logic use_rc;

	// Both views must cover the same word
	if ($bits(insn_t) != `THOR_INSN_W) begin : g_insn_w_chk
		$error("insn_t is not THOR_INSN_W bits wide");
	end

	// Decode-stage register
	always_ff @(posedge clk_g) begin
		if (rst_i)
			dval <= 1'b0;
		else
			dval <= insn_valid_i;
	end

	always_ff @(posedge clk_g) begin
		ir <= insn_i;
	end

	// Execute result bypasses the register file
	// r0 is never forwarded
	function automatic value_t fwd(input reg_idx_t idx, input value_t rf_val);
		if (ex_valid_i && ex_rt_i == idx && idx != '0)
			return ex_res_i;
		return rf_val;
	endfunction

	// Sign-extended immediate
	assign imm_x = {{(`THOR_VALUE_W-`THOR_IMM_W){ir.ri.imm[`THOR_IMM_W-1]}}, ir.ri.imm};

	// ============================================================
	// Opcode map
	// ============================================================
	always_comb begin
		op = A_ADD3;
		rfwr = 1'b1;
		use_imm = 1'b1;
		use_rc = 1'b0;
		case (ir.r3.opcode)
		R2: begin
			use_imm = 1'b0;
			use_rc = 1'b1;
			case (ir.r3.func)
			F_ADD: op = A_ADD3;
			F_SUB: op = A_SUB3;
			F_AND: op = A_AND3;
			F_OR: op = A_OR3;
			F_XOR: op = A_XOR3;
			// Unknown func passes through with no write
			default: rfwr = 1'b0;
			endcase
		end
		// Two-register forms keep c neutral
		ADD2R: use_imm = 1'b0;
		AND2R: begin
			use_imm = 1'b0;
			op = A_AND3;
		end
		OR2R: begin
			use_imm = 1'b0;
			op = A_OR3;
		end
		XOR2R: begin
			use_imm = 1'b0;
			op = A_XOR3;
		end
		ADDI: op = A_ADD3;
		SUBFI: op = A_RSUB;
		ANDI: op = A_AND3;
		ORI: op = A_OR3;
		XORI: op = A_XOR3;
		CMPI: op = A_CMP;
		CMPUI: op = A_CMPU;
		SEQI: op = A_SEQ;
		SNEI: op = A_SNE;
		SLTI: op = A_SLT;
		SGTI: op = A_SGT;
		SLTUI: op = A_SLTU;
		SGTUI: op = A_SGTU;
		default: rfwr = 1'b0;
		endcase
	end

	// Register file reads use indices at fixed positions
	assign rf.ra = ir.r3.ra;
	assign rf.rb = ir.r3.rb;
	assign rf.rc = ir.r3.rc;

	// Bundle towards execute
	assign de.valid = dval;
	assign de.alu_op = op;
	assign de.rt = ir.r3.rt;
	assign de.rfwr = rfwr;

	// Operands follow both the register file and the execute result
	always_comb begin
		de.a = fwd(ir.r3.ra, rf.a);
		de.b = use_imm ? imm_x : fwd(ir.r3.rb, rf.b);
		// Neutral c is all ones for AND and zero for the rest
		de.c = use_rc ? fwd(ir.r3.rc, rf.c) : (op == A_AND3 ? '1 : '0);
	end

	// Opcode seen through the immediate view matches the sampled word
	a_opc_views: assert property (@(posedge clk_g) disable iff (rst_i)
		insn_valid_i |=> dval && ir.ri.opcode == $past(insn_i.r3.opcode));

endmodule

/* verilog/thor_execute.sv */
module thor_execute import thor_pkg::*; (
	input logic clk_g,
	input logic rst_i,
	dec_exe_if.sink de,
	output logic ex_valid_o,
	output reg_idx_t ex_rt_o,
	output value_t ex_res_o
);

	logic xval;
	logic xrfwr;
	alu_op_e xop;
	reg_idx_t xrt;
	value_t xa;
	value_t xb;
	value_t xc;
	value_t res;

	// ============================================================
	// Execute-stage register
	// ============================================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			xval <= 1'b0;
			xrfwr <= 1'b0;
		end else begin
			xval <= de.valid;
			xrfwr <= de.rfwr;
		end
	end

	// Payload, loaded every cycle
	always_ff @(posedge clk_g) begin
		xop <= de.alu_op;
		xrt <= de.rt;
		xa <= de.a;
		xb <= de.b;
		xc <= de.c;
	end

	// ============================================================
	// ALU
	// ============================================================
	always_comb begin
		case (xop)
		A_ADD3: res = xa + xb + xc;
		A_SUB3: res = xa - xb - xc;
		A_AND3: res = xa & xb & xc;
		A_OR3: res = xa | xb | xc;
		A_XOR3: res = xa ^ xb ^ xc;
		// Subtract from immediate
		A_RSUB: res = xb - xa;
		// Three-way compares give -1, 0 or +1
		A_CMP: res = ($signed(xa) < $signed(xb)) ? '1 : (xa == xb ? '0 : value_t'(1));
		A_CMPU: res = (xa < xb) ? '1 : (xa == xb ? '0 : value_t'(1));
		// Sets give 1 or 0
		A_SEQ: res = value_t'(xa == xb);
		A_SNE: res = value_t'(xa != xb);
		A_SLT: res = value_t'($signed(xa) < $signed(xb));
		A_SGT: res = value_t'($signed(xa) > $signed(xb));
		A_SLTU: res = value_t'(xa < xb);
		A_SGTU: res = value_t'(xa > xb);
		default: res = '0;
		endcase
	end

	// Only register writes leave the stage as valid
	assign ex_valid_o = xval & xrfwr;
	assign ex_rt_o = xrt;
	assign ex_res_o = res;

	// Decode never hands over an undefined operation
	a_legal_op: assert property (@(posedge clk_g) disable iff (rst_i)
		xval |-> !$isunknown(xop) && xop <= A_SGTU);

endmodule

/* verilog/thor_writeback.sv */
`include "thor_defs.svh"

module thor_writeback import thor_pkg::*; (
	input logic clk_g,
	input logic rst_i,
	input logic ex_valid_i,
	input reg_idx_t ex_rt_i,
	input value_t ex_res_i,
	rf_read_if.owner rf,
	output logic wb_valid_o,
	output reg_idx_t wb_rt_o,
	output value_t wb_res_o
);

	value_t regfile [`THOR_REG_N];

	// ============================================================
	// Register file
	// ============================================================
	// r0 is never written
	always_ff @(posedge clk_g) begin
		if (ex_valid_i && ex_rt_i != '0)
			regfile[ex_rt_i] <= ex_res_i;
	end

	// Asynchronous reads, r0 forced to zero
	assign rf.a = (rf.ra == '0) ? '0 : regfile[rf.ra];
	assign rf.b = (rf.rb == '0) ? '0 : regfile[rf.rb];
	assign rf.c = (rf.rc == '0) ? '0 : regfile[rf.rc];

	// Result report, same edge as the write
	always_ff @(posedge clk_g) begin
		if (rst_i)
			wb_valid_o <= 1'b0;
		else
			wb_valid_o <= ex_valid_i;
	end

	always_ff @(posedge clk_g) begin
		wb_rt_o <= ex_rt_i;
		wb_res_o <= ex_res_i;
	end

	// No report leaks out right after reset
	a_quiet_after_rst: assert property (@(posedge clk_g) rst_i |=> !wb_valid_o);

endmodule

/* verilog/thor_core.sv */
module thor_core import thor_pkg::*; (
	input logic clk_g,
	input logic rst_i,
	input logic insn_valid_i,
	input insn_t insn_i,
	output logic wb_valid_o,
	output reg_idx_t wb_rt_o,
	output value_t wb_res_o
);

	// Execute result, to writeback and back to decode
	logic ex_valid;
	reg_idx_t ex_rt;
	value_t ex_res;

	rf_read_if rf_bus ();
	dec_exe_if de_bus ();

	// ============================================================
	// Decode and operand read
	// ============================================================
	thor_decode u_decode (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.insn_valid_i(insn_valid_i),
		.insn_i(insn_i),
		.rf(rf_bus.reader),
		.de(de_bus.source),
		.ex_valid_i(ex_valid),
		.ex_rt_i(ex_rt),
		.ex_res_i(ex_res)
	);

	// Execute
	thor_execute u_execute (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.de(de_bus.sink),
		.ex_valid_o(ex_valid),
		.ex_rt_o(ex_rt),
		.ex_res_o(ex_res)
	);

	// Register file and result report
	thor_writeback u_writeback (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.ex_valid_i(ex_valid),
		.ex_rt_i(ex_rt),
		.ex_res_i(ex_res),
		.rf(rf_bus.owner),
		.wb_valid_o(wb_valid_o),
		.wb_rt_o(wb_rt_o),
		.wb_res_o(wb_res_o)
	);

endmodule

/* bench/tb_clock.sv */
module tb_clock (
	output logic clk_g
);
	timeunit 1ns;
	timeprecision 1ps;

	// Free-running clock, 10 ns period
	initial clk_g = 1'b0;

	always #5 clk_g = ~clk_g;

endmodule

/* bench/tb_thor.sv */
`include "thor_defs.svh"

module tb_thor import thor_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// Fixed tests are 15 loads, 4 imm, 5 R2, 4 2R, 2 setup, 32 compares and 4 odd cases
	localparam int N_FIXED = 66;
	localparam int N_BURST = 200;
	localparam int N_INSN = N_FIXED + N_BURST;
	localparam int WD_TIME = (N_INSN + 16 + 50) * 10;

	// One expected write-back stamped with its issue cycle
	typedef struct {
		int cyc;
		reg_idx_t rt;
		value_t res;
		string name;
	} exp_t;

	logic clk_g;
	logic rst_i;
	logic insn_valid_i;
	insn_t insn_i;
	logic wb_valid_o;
	reg_idx_t wb_rt_o;
	value_t wb_res_o;

	int seed = 32'h46cfa953;
	int cyc = 0;
	int n_issued = 0;
	int err_value = 0;
	int err_timing = 0;
	value_t rf_m [`THOR_REG_N];
	exp_t exp_q [$];
	logic head_ok = 1'b0;
	int head_cyc = 0;
	reg_idx_t head_rt = '0;
	value_t head_res = '0;
	string head_name = "";

	logic [6:0] op_list [18] = '{R2, ADD2R, AND2R, OR2R, XOR2R, ADDI, SUBFI, ANDI, ORI,
		XORI, CMPI, CMPUI, SEQI, SNEI, SLTI, SGTI, SLTUI, SGTUI};
	logic [6:0] cs_list [8] = '{CMPI, CMPUI, SEQI, SNEI, SLTI, SGTI, SLTUI, SGTUI};
	logic [8:0] fn_list [5] = '{F_ADD, F_SUB, F_AND, F_OR, F_XOR};

	tb_clock u_clock (.clk_g(clk_g));

	thor_core uut (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.insn_valid_i(insn_valid_i),
		.insn_i(insn_i),
		.wb_valid_o(wb_valid_o),
		.wb_rt_o(wb_rt_o),
		.wb_res_o(wb_res_o)
	);

	// ============================================================
	// Reference model
	// ============================================================
	// Returns 1 when the instruction writes a register
	function automatic logic model_op(input logic [6:0] opc, input logic [8:0] fn,
		input value_t a, input value_t b, input value_t c, input value_t imm,
		output value_t res);
		res = '0;
		case (opc)
		R2: begin
			case (fn)
			F_ADD: res = a + b + c;
			F_SUB: res = a - b - c;
			F_AND: res = a & b & c;
			F_OR: res = a | b | c;
			F_XOR: res = a ^ b ^ c;
			default: return 1'b0;
			endcase
		end
		ADD2R: res = a + b;
		AND2R: res = a & b;
		OR2R: res = a | b;
		XOR2R: res = a ^ b;
		ADDI: res = a + imm;
		SUBFI: res = imm - a;
		ANDI: res = a & imm;
		ORI: res = a | imm;
		XORI: res = a ^ imm;
		// -1 below, 0 equal, +1 above
		CMPI: res = ($signed(a) < $signed(imm)) ? {64{1'b1}} : ((a == imm) ? 64'd0 : 64'd1);
		CMPUI: res = (a < imm) ? {64{1'b1}} : ((a == imm) ? 64'd0 : 64'd1);
		SEQI: res = (a == imm) ? 64'd1 : 64'd0;
		SNEI: res = (a != imm) ? 64'd1 : 64'd0;
		SLTI: res = ($signed(a) < $signed(imm)) ? 64'd1 : 64'd0;
		SGTI: res = ($signed(a) > $signed(imm)) ? 64'd1 : 64'd0;
		SLTUI: res = (a < imm) ? 64'd1 : 64'd0;
		SGTUI: res = (a > imm) ? 64'd1 : 64'd0;
		default: return 1'b0;
		endcase
		return 1'b1;
	endfunction

	function automatic reg_idx_t rand_reg();
		logic [31:0] r;
		r = $random(seed);
		// Burst stays within the preloaded r0..r15
		return {2'b00, r[3:0]};
	endfunction

	function automatic logic [20:0] rand_imm();
		logic [31:0] r;
		r = $random(seed);
		return r[20:0];
	endfunction

	function automatic int rand_pick(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[15:0]) % n;
	endfunction

	// Drive one instruction on the falling edge and log what it must produce
	task automatic issue(input string name, input logic [6:0] opc, input reg_idx_t rt,
		input reg_idx_t ra, input reg_idx_t rb, input reg_idx_t rc, input logic [8:0] fn,
		input logic [20:0] imm);
		insn_t w;
		value_t imm_x;
		value_t res;
		exp_t e;
		imm_x = {{43{imm[20]}}, imm};
		w = '0;
		w.r3.opcode = opcode_e'(opc);
		w.r3.rt = rt;
		w.r3.ra = ra;
		w.r3.rb = rb;
		w.r3.rc = rc;
		w.r3.func = func_e'(fn);
		// Immediate overlays rb, rc and func
		if (!(opc == R2 || opc == ADD2R || opc == AND2R || opc == OR2R || opc == XOR2R))
			w.ri.imm = imm;
		@(negedge clk_g);
		insn_valid_i = 1'b1;
		insn_i = w;
		if (model_op(opc, fn, rf_m[ra], rf_m[rb], rf_m[rc], imm_x, res)) begin
			if (rt != '0)
				rf_m[rt] = res;
			e.cyc = cyc;
			e.rt = rt;
			e.res = res;
			e.name = name;
			exp_q.push_back(e);
		end
		n_issued++;
	endtask

	task automatic idle();
		@(negedge clk_g);
		insn_valid_i = 1'b0;
	endtask

	// Cycle count and queue head move on the rising edge
	// An entry is due when cyc reaches its stamp plus three
	always @(posedge clk_g) begin
		if (exp_q.size() != 0 && exp_q[0].cyc + 3 <= cyc)
			void'(exp_q.pop_front());
		cyc = cyc + 1;
		head_ok = (exp_q.size() != 0);
		if (head_ok) begin
			head_cyc = exp_q[0].cyc;
			head_rt = exp_q[0].rt;
			head_res = exp_q[0].res;
			head_name = exp_q[0].name;
		end
	end

	// ============================================================
	// Checks sampled mid-cycle where outputs are stable
	// ============================================================
	a_quiet: assert property (@(negedge clk_g) (cyc > 0 && n_issued == 0) |-> !wb_valid_o)
		else begin
			err_timing++;
			$display("Write-back pulse seen before any instruction was issued");
		end

	a_no_extra: assert property (@(negedge clk_g) disable iff (rst_i)
		wb_valid_o |-> head_ok && cyc == head_cyc + 3)
		else begin
			err_timing++;
			$display("Unexpected write-back pulse at cycle %0d", cyc);
		end

	a_no_miss: assert property (@(negedge clk_g) disable iff (rst_i)
		(head_ok && cyc == head_cyc + 3) |-> wb_valid_o)
		else begin
			err_timing++;
			$display("Missing write-back pulse for %s issued at cycle %0d", head_name, head_cyc);
		end

	a_rt: assert property (@(negedge clk_g) disable iff (rst_i)
		(wb_valid_o && head_ok && cyc == head_cyc + 3) |-> wb_rt_o == head_rt)
		else begin
			err_value++;
			$display("ERR %s rt expected %0d actual %0d", head_name, head_rt, wb_rt_o);
		end

	a_res: assert property (@(negedge clk_g) disable iff (rst_i)
		(wb_valid_o && head_ok && cyc == head_cyc + 3) |-> wb_res_o == head_res)
		else begin
			err_value++;
			$display("ERR %s result expected %h actual %h", head_name, head_res, wb_res_o);
		end

	// Watchdog sized from the instruction count
	initial begin
		#(WD_TIME);
		$display("Timeout after %0d ns with %0d results outstanding", WD_TIME, exp_q.size());
		$display("Simulation failed");
		$finish;
	end

	// ============================================================
	// Stimulus
	// ============================================================
	initial begin
		int i;
		int s;
		int k;
		logic [6:0] opc;
		reg_idx_t rt;
		reg_idx_t prev_rt;
		logic [20:0] imms [2];
		reg_idx_t srcs [2];
		rst_i = 1'b1;
		insn_valid_i = 1'b0;
		insn_i = '0;
		for (i = 0; i < `THOR_REG_N; i++)
			rf_m[i] = '0;
		repeat (16) @(negedge clk_g);
		rst_i = 1'b0;

		// ADDI from r0 loads r1..r15
		for (i = 1; i < 16; i++)
			issue("addi_load", ADDI, reg_idx_t'(i), 6'd0, 6'd0, 6'd0, 9'h0, rand_imm());
		issue("subfi", SUBFI, 6'd6, 6'd1, 6'd0, 6'd0, 9'h0, rand_imm());
		issue("andi", ANDI, 6'd7, 6'd2, 6'd0, 6'd0, 9'h0, rand_imm());
		issue("ori", ORI, 6'd8, 6'd3, 6'd0, 6'd0, 9'h0, rand_imm());
		issue("xori", XORI, 6'd9, 6'd4, 6'd0, 6'd0, 9'h0, rand_imm());

		for (i = 0; i < 5; i++)
			issue("r2_group", R2, 6'd13, 6'd1, 6'd2, 6'd3, fn_list[i], 21'h0);
		issue("add2r", ADD2R, 6'd14, 6'd4, 6'd5, 6'd0, 9'h0, 21'h0);
		issue("and2r", AND2R, 6'd14, 6'd14, 6'd6, 6'd0, 9'h0, 21'h0);
		issue("or2r", OR2R, 6'd15, 6'd7, 6'd8, 6'd0, 9'h0, 21'h0);
		issue("xor2r", XOR2R, 6'd15, 6'd15, 6'd9, 6'd0, 9'h0, 21'h0);

		// Negative against positive splits the signed and unsigned order
		issue("cmp_setup", ADDI, 6'd9, 6'd0, 6'd0, 6'd0, 9'h0, -21'd5);
		issue("cmp_setup", ADDI, 6'd10, 6'd0, 6'd0, 6'd0, 9'h0, 21'd3);
		srcs[0] = 6'd9;
		srcs[1] = 6'd10;
		imms[0] = 21'd3;
		imms[1] = -21'd5;
		for (s = 0; s < 2; s++)
			for (i = 0; i < 2; i++)
				for (k = 0; k < 8; k++)
					issue("cmp_set", cs_list[k], 6'd12, srcs[s], 6'd0, 6'd0, 9'h0, imms[i]);

		// Back-to-back burst with sources often the previous target
		prev_rt = 6'd1;
		for (i = 0; i < N_BURST; i++) begin
			opc = op_list[rand_pick(18)];
			rt = rand_reg();
			if (rt == '0)
				rt = 6'd1;
			issue("burst", opc, rt, rand_pick(2) ? prev_rt : rand_reg(),
				rand_pick(2) ? prev_rt : rand_reg(), rand_reg(), fn_list[rand_pick(5)],
				rand_imm());
			prev_rt = rt;
		end

		// Odd cases with no pulse for the two unknowns
		issue("bad_opcode", 7'h7F, 6'd5, 6'd1, 6'd2, 6'd3, 9'h0, 21'h0);
		issue("bad_func", R2, 6'd5, 6'd1, 6'd2, 6'd3, 9'h1FF, 21'h0);
		issue("rt_zero", ADDI, 6'd0, 6'd0, 6'd0, 6'd0, 9'h0, rand_imm());
		issue("r0_read", OR2R, 6'd11, 6'd0, 6'd0, 6'd0, 9'h0, 21'h0);
		idle();

		while (exp_q.size() != 0)
			@(posedge clk_g);
		// A few quiet cycles catch a late pulse
		repeat (4) @(negedge clk_g);
		@(posedge clk_g);

		$display("Issued %0d, value errors %0d, timing errors %0d", n_issued, err_value,
			err_timing);
		if (err_value == 0 && err_timing == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+verilog
verilog/thor_pkg.sv
verilog/thor_if.sv
verilog/thor_decode.sv
verilog/thor_execute.sv
verilog/thor_writeback.sv
verilog/thor_core.sv
bench/tb_clock.sv
bench/tb_thor.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_thor
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing --timescale 1ns/1ps -j 0
PASS_MSG ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
